// File: filelist.f
+incdir+testbench
hdl/memPkg.sv
hdl/addressUnit.sv
hdl/storeAligner.sv
hdl/dataMemory.sv
hdl/loadFormatter.sv
hdl/memStage.sv
testbench/memStageTb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := memStageTb
FILELIST  := filelist.f
OBJDIR    := obj_dir
BIN       := $(OBJDIR)/V$(TOP)
LOG       := sim.log
PASS_TEXT := PASS: all tests

SOURCES := $(wildcard hdl/*.sv) $(wildcard testbench/*.sv) $(wildcard testbench/*.svh)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation failed" && exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: testbench/memModel.svh
`ifndef MEMMODEL_SVH
`define MEMMODEL_SVH

localparam int ModelWords = 256;                  // Depth of the DUT instance
localparam int ByteBits   = $clog2(ModelWords * 4);

// Shadow of the DUT memory, one entry per byte, little endian
logic [7:0] shadow [ModelWords * 4];

function automatic logic [7:0] readShadow(input logic [31:0] addr);
    return shadow[addr[ByteBits-1:0]];
endfunction

// Fault rule: illegal size, misaligned half or word, word index past the end
function automatic bit expectFault(input logic [31:0] addr, input logic [1:0] sizeCode);
    bit fault;
    case (sizeCode)
        2'd0:    fault = (addr[1:0] != 2'b00);
        2'd1:    fault = addr[0];
        2'd2:    fault = 1'b0;
        default: fault = 1'b1;                    // Size 3
    endcase
    if (addr[31:2] >= 30'(ModelWords)) fault = 1'b1;
    return fault;
endfunction

// Loaded value for a non-faulting load
function automatic logic [31:0] expectLoad(input logic [31:0] addr,
                                           input logic [1:0] sizeCode,
                                           input bit isUnsigned);
    logic [31:0] wordBase;
    logic [15:0] half;
    logic [7:0]  oneByte;
    logic [31:0] result;
    wordBase = {addr[31:2], 2'b00};
    oneByte  = readShadow(addr);
    half     = {readShadow(addr + 32'd1), readShadow(addr)};  // Low byte at lower address
    case (sizeCode)
        2'd1:    result = isUnsigned ? {16'b0, half} : {{16{half[15]}}, half};
        2'd2:    result = isUnsigned ? {24'b0, oneByte} : {{24{oneByte[7]}}, oneByte};
        default: result = {readShadow(wordBase + 32'd3), readShadow(wordBase + 32'd2),
                           readShadow(wordBase + 32'd1), readShadow(wordBase)};
    endcase
    return result;
endfunction

// Non-faulting store into the shadow
function automatic void storeShadow(input logic [31:0] addr, input logic [1:0] sizeCode,
                                    input logic [31:0] data);
    logic [31:0] byteAddr;
    int          count;
    count = (sizeCode == 2'd2) ? 1 : ((sizeCode == 2'd1) ? 2 : 4);
    for (int n = 0; n < count; n++) begin
        byteAddr = addr + 32'(n);
        shadow[byteAddr[ByteBits-1:0]] = data[8*n +: 8];
    end
endfunction

`endif

// File: testbench/memStageTb.sv
`timescale 1ns/1ps

module memStageTb import memPkg::*; ();

    `include "memModel.svh"

    localparam int RandomReqs   = 400;
    localparam int DirectedReqs = 16 + 12 + 13 + 12;  // Directed tests after the fill
    localparam int CycleLimit   = ModelWords + DirectedReqs + RandomReqs + 50;

    // Expected outcome of one request and the edge it is due at
    typedef struct packed {
        int   dueCycle;
        logic expValid;
        logic expFault;
        wordT expData;
    } resultT;

    logic       Clock;
    logic       rstN;
    logic       MemRead;
    logic       MemWrite;
    accessSizeT AccessSize;
    logic       LoadUnsigned;
    addrT       BaseAddr;
    offsetT     Offset;
    wordT       WriteData;
    wordT       ReadData;
    logic       ReadValid;
    logic       AccessFault;

    resultT pending [$];                  // Requests in flight
    int     cycleCount      = 0;
    int     errorCount      = 0;
    int     checkCount      = 0;
    int     testCount       = 0;
    int     testErrorsStart = 0;

    memStage #(
        .MemWords (ModelWords)
    ) i_dut (
        .Clock        (Clock),
        .rstN         (rstN),
        .MemRead      (MemRead),
        .MemWrite     (MemWrite),
        .AccessSize   (AccessSize),
        .LoadUnsigned (LoadUnsigned),
        .BaseAddr     (BaseAddr),
        .Offset       (Offset),
        .WriteData    (WriteData),
        .ReadData     (ReadData),
        .ReadValid    (ReadValid),
        .AccessFault  (AccessFault)
    );

    initial begin
        Clock = 1'b0;
        forever #10 Clock = ~Clock;       // 20 ns period
    end

    // Fill value mixes every address bit
    function automatic wordT fillPattern(input addrT addr);
        return (addr * 32'h9E3779B1) ^ 32'h5A5A0F0F;
    endfunction

    // Presents one request at the next edge and queues its expected result
    task automatic issue(input bit isLoad, input bit isStore, input logic [1:0] sizeCode,
                         input bit isUnsigned, input addrT base, input offsetT off,
                         input wordT data);
        resultT entry;
        addrT   addr;
        bit     fault;
        @(posedge Clock);
        #2;
        MemRead      = isLoad;
        MemWrite     = isStore;
        AccessSize   = accessSizeT'(sizeCode);
        LoadUnsigned = isUnsigned;
        BaseAddr     = base;
        Offset       = off;
        WriteData    = data;
        addr  = base + {{16{off[15]}}, off};
        fault = expectFault(addr, sizeCode);
        entry.dueCycle = cycleCount + 2;
        entry.expValid = isLoad && !fault;
        entry.expFault = fault;
        entry.expData  = (isLoad && !fault) ? expectLoad(addr, sizeCode, isUnsigned) : '0;
        if (isStore && !fault) storeShadow(addr, sizeCode, data);
        pending.push_back(entry);
    endtask

    task automatic idleCycle();
        @(posedge Clock);
        #2;
        MemRead  = 1'b0;
        MemWrite = 1'b0;
    endtask

    // Drains the pipeline and reports the errors of this test
    task automatic finishTest(input string name);
        int newErrors;
        idleCycle();
        while (pending.size() > 0) begin
            @(posedge Clock);
            #1;
        end
        newErrors       = errorCount - testErrorsStart;
        testErrorsStart = errorCount;
        testCount++;
        if (newErrors == 0) $display("test %0d %s: ok", testCount, name);
        else $display("test %0d %s: %0d errors", testCount, name, newErrors);
    endtask

    // Compares the outputs as they were just before the edge
    always @(posedge Clock) begin : compareOutputs
        resultT expected;
        cycleCount = cycleCount + 1;
        if (rstN) begin
            if (pending.size() > 0 && pending[0].dueCycle == cycleCount) begin
                expected = pending.pop_front();
            end else begin
                expected = '0;            // Outputs idle when no result is due
            end
            checkCount++;
            assert (ReadValid === expected.expValid) else begin
                errorCount++;
                $display("[ERROR] %0t: ReadValid %b, expected %b", $time, ReadValid,
                         expected.expValid);
            end
            assert (AccessFault === expected.expFault) else begin
                errorCount++;
                $display("[ERROR] %0t: AccessFault %b, expected %b", $time, AccessFault,
                         expected.expFault);
            end
            assert (ReadData === expected.expData) else begin
                errorCount++;
                $display("[ERROR] %0t: ReadData 0x%08h, expected 0x%08h", $time, ReadData,
                         expected.expData);
            end
        end
    end

    initial begin
        wait (cycleCount >= CycleLimit);
        $display("Timeout: the run did not finish within %0d cycles", CycleLimit);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        addrT       byteAddr;
        addrT       lastStoreAddr;
        bit         lastWasStore;
        bit         isLoad;
        logic [1:0] sizeCode;
        int         offInt;
        offsetT     off;
        void'($urandom(15442));
        MemRead      = 1'b0;
        MemWrite     = 1'b0;
        AccessSize   = sizeWord;
        LoadUnsigned = 1'b0;
        BaseAddr     = '0;
        Offset       = '0;
        WriteData    = '0;
        rstN         = 1'b0;
        repeat (4) @(posedge Clock);
        #2 rstN = 1'b1;

        repeat (3) idleCycle();           // Outputs must stay quiet with no request
        finishTest("reset idle");

        for (int w = 0; w < ModelWords; w++) begin
            issue(0, 1, 2'd0, 0, 32'(w * 4), 16'sd0, fillPattern(32'(w * 4)));
        end
        finishTest("memory fill");

        // Negative offsets below word 128
        for (int i = 0; i < 8; i++) begin
            issue(0, 1, 2'd0, 0, 32'h200, offsetT'(-4 * (i + 1)), $urandom);
            issue(1, 0, 2'd0, 0, 32'h200, offsetT'(-4 * (i + 1)), '0);
        end
        finishTest("word store and load");

        for (int lane = 0; lane < 4; lane++) begin
            issue(0, 1, 2'd2, 0, 32'h40, offsetT'(lane), $urandom);
            issue(1, 0, 2'd0, 0, 32'h40, 16'sd0, '0);
        end
        for (int lane = 0; lane < 4; lane += 2) begin
            issue(0, 1, 2'd1, 0, 32'h40, offsetT'(lane), $urandom);
            issue(1, 0, 2'd0, 0, 32'h40, 16'sd0, '0);
        end
        finishTest("byte and half lanes");

        issue(0, 1, 2'd0, 0, 32'h80, 16'sd0, 32'hFF80017F);  // Bytes and halves of both signs
        for (int lane = 0; lane < 4; lane++) begin
            issue(1, 0, 2'd2, 0, 32'h80, offsetT'(lane), '0);
            issue(1, 0, 2'd2, 1, 32'h80, offsetT'(lane), '0);
        end
        for (int lane = 0; lane < 4; lane += 2) begin
            issue(1, 0, 2'd1, 0, 32'h80, offsetT'(lane), '0);
            issue(1, 0, 2'd1, 1, 32'h80, offsetT'(lane), '0);
        end
        finishTest("load extension");

        issue(0, 1, 2'd1, 0, 32'hC0, 16'sd1, 32'hDEADBEEF);  // Misaligned half
        issue(0, 1, 2'd0, 0, 32'hC0, 16'sd2, 32'hDEADBEEF);
        issue(0, 1, 2'd0, 0, 32'hC0, 16'sd1, 32'hDEADBEEF);
        issue(0, 1, 2'd3, 0, 32'hC0, 16'sd0, 32'hDEADBEEF);  // Illegal size
        issue(0, 1, 2'd0, 0, 32'h400, 16'sd0, 32'hDEADBEEF); // Would alias word 0
        issue(1, 0, 2'd0, 0, 32'hC0, 16'sd0, '0);
        issue(1, 0, 2'd0, 0, 32'h0, 16'sd0, '0);
        issue(1, 0, 2'd1, 0, 32'hC0, 16'sd3, '0);
        issue(1, 0, 2'd0, 0, 32'hC0, 16'sd2, '0);
        issue(1, 0, 2'd3, 0, 32'hC0, 16'sd0, '0);
        issue(1, 0, 2'd2, 0, 32'h400, 16'sd0, '0);
        issue(1, 0, 2'd0, 0, 32'h0, -16'sd4, '0);            // Wraps to the top of space
        finishTest("faults");

        lastWasStore  = 1'b0;
        lastStoreAddr = '0;
        for (int n = 0; n < RandomReqs; n++) begin
            isLoad   = 1'($urandom_range(0, 1));
            sizeCode = 2'($urandom_range(0, 2));
            if ($urandom_range(0, 19) == 0) sizeCode = 2'd3;
            if (isLoad && lastWasStore && $urandom_range(0, 1) == 1) begin
                byteAddr = {lastStoreAddr[31:2], 2'($urandom_range(0, 3))};  // Same word
            end else begin
                byteAddr = $urandom_range(0, 31);
            end
            if ($urandom_range(0, 7) != 0) begin    // Mostly aligned
                if (sizeCode == 2'd1) byteAddr[0] = 1'b0;
                if (sizeCode == 2'd0) byteAddr[1:0] = 2'b00;
            end
            if ($urandom_range(0, 31) == 0) byteAddr = byteAddr + 32'h400;
            offInt = int'($urandom_range(0, 255)) - 128;
            off    = offsetT'(offInt);
            issue(isLoad, !isLoad, sizeCode, 1'($urandom_range(0, 1)),
                  byteAddr - {{16{off[15]}}, off}, off, $urandom);
            lastWasStore = !isLoad;
            if (!isLoad) lastStoreAddr = byteAddr;
        end
        finishTest("random stream");

        $display("summary: %0d tests, %0d cycles checked, %0d errors", testCount, checkCount,
                 errorCount);
        if (errorCount == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: hdl/memStage.sv
`timescale 1ns/1ps

module memStage import memPkg::*; #(
    parameter int MemWords = 4096      // Depth in words, passed to both users
) (
    input  logic       Clock,
    input  logic       rstN,
    input  logic       MemRead,        // Load request this cycle
    input  logic       MemWrite,       // Store request this cycle
    input  accessSizeT AccessSize,
    input  logic       LoadUnsigned,
    input  addrT       BaseAddr,
    input  offsetT     Offset,
    input  wordT       WriteData,
    output wordT       ReadData,       // Valid in the cycle after the load
    output logic       ReadValid,
    output logic       AccessFault
);

    localparam int IndexW = $clog2(MemWords);

    addrT              effAddr;
    logic              fault;
    wordT              laneData;
    byteEnT            byteEn;
    wordT              rawWord;
    logic [IndexW-1:0] wordIndex;
    logic [1:0]        byteOffset;
    logic              memWriteEn;
    logic              memReadEn;

    assign wordIndex  = effAddr[IndexW+1:2];  // Range already checked on the full address
    assign byteOffset = effAddr[1:0];

    // A faulting access never touches the array
    assign memWriteEn = MemWrite & ~fault;
    assign memReadEn  = MemRead & ~fault;

    addressUnit #(
        .MemWords (MemWords)
    ) i_addressUnit (
        .BaseAddr   (BaseAddr),
        .Offset     (Offset),
        .AccessSize (AccessSize),
        .EffAddr    (effAddr),
        .Fault      (fault)
    );

    storeAligner i_storeAligner (
        .WriteData  (WriteData),
        .AccessSize (AccessSize),
        .ByteOffset (byteOffset),
        .LaneData   (laneData),
        .ByteEn     (byteEn)
    );

    dataMemory #(
        .MemWords (MemWords)
    ) i_dataMemory (
        .Clock     (Clock),
        .WordIndex (wordIndex),
        .WriteEn   (memWriteEn),
        .ByteEn    (byteEn),
        .LaneData  (laneData),
        .ReadEn    (memReadEn),
        .RawWord   (rawWord)
    );

    loadFormatter i_loadFormatter (
        .Clock        (Clock),
        .rstN         (rstN),
        .ReadReq      (MemRead),
        .Fault        (fault),
        .WriteReq     (MemWrite),
        .AccessSize   (AccessSize),
        .LoadUnsigned (LoadUnsigned),
        .ByteOffset   (byteOffset),
        .RawWord      (rawWord),
        .ReadData     (ReadData),
        .ReadValid    (ReadValid),
        .AccessFault  (AccessFault)
    );

    // Address arithmetic has to be resolved whenever a request is presented
    effAddrKnown: assert property (@(posedge Clock) disable iff (!rstN)
        (MemRead || MemWrite) |-> !$isunknown(effAddr))
        else $error("memStage: effective address unknown during a request");

endmodule

// File: hdl/loadFormatter.sv
`timescale 1ns/1ps

module loadFormatter import memPkg::*; (
    input  logic       Clock,
    input  logic       rstN,
    input  logic       ReadReq,        // MemRead of the request at this edge
    input  logic       Fault,          // From the address unit, same cycle
    input  logic       WriteReq,       // MemWrite of the request at this edge
    input  accessSizeT AccessSize,
    input  logic       LoadUnsigned,   // lbu / lhu
    input  logic [1:0] ByteOffset,
    input  wordT       RawWord,        // Registered word from the memory
    output wordT       ReadData,
    output logic       ReadValid,
    output logic       AccessFault
);

    accessSizeT sizeQ;                 // Request fields delayed to match RawWord
    logic       unsignedQ;
    logic [1:0] laneQ;
    logic       loadValidQ;            // Load without fault issued last edge
    logic       faultQ;                // Any request with fault issued last edge
    byteT       laneByte;
    halfT       laneHalf;

    // Control bits
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            loadValidQ <= 1'b0;
            faultQ     <= 1'b0;
        end else begin
            loadValidQ <= ReadReq & ~Fault;
            faultQ     <= (ReadReq | WriteReq) & Fault;
        end
    end

    // Format fields, only looked at when loadValidQ is set
    always_ff @(posedge Clock) begin
        sizeQ     <= AccessSize;
        unsignedQ <= LoadUnsigned;
        laneQ     <= ByteOffset;
    end

    // Lane select
    assign laneByte = RawWord[8*laneQ +: 8];
    assign laneHalf = laneQ[1] ? RawWord[31:16] : RawWord[15:0];  // Bit 0 is clear here

    always_comb begin
        if (!loadValidQ) begin
            ReadData = '0;                                        // Idle or faulted
        end else begin
            case (sizeQ)
                sizeByte: ReadData = unsignedQ ? {24'b0, laneByte}
                                               : {{24{laneByte[7]}}, laneByte};
                sizeHalf: ReadData = unsignedQ ? {16'b0, laneHalf}
                                               : {{16{laneHalf[15]}}, laneHalf};
                default:  ReadData = RawWord;                     // Full word
            endcase
        end
    end

    assign ReadValid   = loadValidQ;
    assign AccessFault = faultQ;

    // A result cycle carries either data or a fault, never both
    validXorFault: assert property (@(posedge Clock) disable iff (!rstN)
        !(ReadValid && AccessFault))
        else $error("loadFormatter: ReadValid and AccessFault both high");

endmodule

// File: hdl/dataMemory.sv
`timescale 1ns/1ps

module dataMemory import memPkg::*; #(
    parameter int MemWords = 4096                 // Number of 32-bit words
) (
    input  logic                        Clock,
    input  logic [$clog2(MemWords)-1:0] WordIndex, // Byte address divided by 4
    input  logic                        WriteEn,   // Already gated by the fault
    input  byteEnT                      ByteEn,
    input  wordT                        LaneData,
    input  logic                        ReadEn,    // Already gated by the fault
    output wordT                        RawWord    // Whole word, lane select is later
);

    wordT mem [MemWords];                         // Contents are not initialised

    // Byte-lane write, one 8-bit slice per enabled lane
    always_ff @(posedge Clock) begin
        if (WriteEn) begin
            for (int lane = 0; lane < ByteLanes; lane++) begin
                if (ByteEn[lane]) begin
                    mem[WordIndex][8*lane +: 8] <= LaneData[8*lane +: 8];
                end
            end
        end
    end

    // Registered read, holds the last word while idle
    always_ff @(posedge Clock) begin
        if (ReadEn) begin
            RawWord <= mem[WordIndex];
        end
    end

    // The stage issues one request per cycle, so read and write never meet
    // on the same edge and no read-during-write behaviour is needed
    rdWrExclusive: assert property (@(posedge Clock) !(WriteEn && ReadEn))
        else $error("dataMemory: read and write enabled together");

    // Every store size produces at least one lane in the aligner
    wrHasLanes: assert property (@(posedge Clock) WriteEn |-> (ByteEn != '0))
        else $error("dataMemory: write with empty byte mask");

endmodule

// File: hdl/storeAligner.sv
`timescale 1ns/1ps

module storeAligner import memPkg::*; (
    input  wordT       WriteData,      // Store data from the register file
    input  accessSizeT AccessSize,
    input  logic [1:0] ByteOffset,     // Low two bits of the effective address
    output wordT       LaneData,       // Data placed on every lane it could land in
    output byteEnT     ByteEn          // Lanes actually written
);

    // The low byte or half is copied to all lanes, so the mask alone
    // picks where it lands. Alignment is checked by the address unit
    always_comb begin
        case (AccessSize)
            sizeByte: begin
                LaneData = {4{WriteData[7:0]}};
                ByteEn   = byteEnT'(4'b0001 << ByteOffset);  // One lane
            end
            sizeHalf: begin
                LaneData = {2{WriteData[15:0]}};
                // Upper or lower half, bit 0 is a fault anyway
                if (ByteOffset[1]) begin
                    ByteEn = 4'b1100;
                end else begin
                    ByteEn = 4'b0011;
                end
            end
            default: begin
                // Word store, size 3 lands here too but never writes
                LaneData = WriteData;
                ByteEn   = 4'b1111;
            end
        endcase
    end

endmodule

// File: hdl/addressUnit.sv
`timescale 1ns/1ps

module addressUnit import memPkg::*; #(
    parameter int MemWords = 4096      // Depth in words, for the range check
) (
    input  addrT       BaseAddr,       // Base register value
    input  offsetT     Offset,         // Signed 16-bit displacement
    input  accessSizeT AccessSize,
    output addrT       EffAddr,
    output logic       Fault
);

    addrT offsetExt;                   // Offset widened to 32 bits
    logic misaligned;
    logic badSize;
    logic outOfRange;

    // Sign extension then plain 32-bit add, wraps like the ALU does
    assign offsetExt = {{16{Offset[15]}}, Offset};
    assign EffAddr   = BaseAddr + offsetExt;

    // Alignment depends on the access size
    always_comb begin
        misaligned = 1'b0;
        badSize    = 1'b0;
        case (AccessSize)
            sizeWord: misaligned = |EffAddr[1:0];  // Both low bits must be clear
            sizeHalf: misaligned = EffAddr[0];     // Halfword boundary
            sizeByte: misaligned = 1'b0;           // Any byte address is fine
            default:  badSize    = 1'b1;           // Encoding 3
        endcase
    end

    // Word index compared against the depth, upper address bits included
    assign outOfRange = {2'b00, EffAddr[31:2]} >= addrT'(MemWords);

    assign Fault = misaligned | badSize | outOfRange;

endmodule

// File: hdl/memPkg.sv
package memPkg;

    // Byte lanes in one data word
    localparam int ByteLanes = 4;

    // 32-bit data word for store data, memory words and load results
    typedef logic [31:0] wordT;

    // Byte address as produced by base plus offset
    typedef logic [31:0] addrT;

    // Signed immediate from the instruction word
    typedef logic signed [15:0] offsetT;

    // Write mask where bit n covers bits 8n+7 down to 8n
    typedef logic [ByteLanes-1:0] byteEnT;

    // Sub-word pieces picked out by the load path
    typedef logic [7:0]  byteT;
    typedef logic [15:0] halfT;

    // Access size encoding of the MIPS load and store group
    // Value 3 is not named and counts as a fault
    typedef enum logic [1:0] {
        sizeWord = 2'd0,     // lw / sw
        sizeHalf = 2'd1,     // lh / lhu / sh
        sizeByte = 2'd2      // lb / lbu / sb
    } accessSizeT;

endpackage
